/* design/exuCfgPkg.sv */
package exuCfgPkg;

    // data and address width of the RV64 core
    localparam int RegWidth = 64;

    // fixed instruction length, no compressed set
    localparam int InstWidth = 32;

    // width the W-type operations work on
    localparam int WordWidth = 32;

endpackage

/* design/exuCtrlPkg.sv */
package exuCtrlPkg;

    // ALU operation select
    typedef enum logic [4:0] {
        AluAdd   = 5'd0,
        AluSub   = 5'd1,
        AluSll   = 5'd2,
        AluSlt   = 5'd3,
        AluSltu  = 5'd4,
        AluXor   = 5'd5,
        AluSrl   = 5'd6,
        AluSra   = 5'd7,
        AluOr    = 5'd8,
        AluAnd   = 5'd9,
        AluCopyB = 5'd10
    } aluOp_t;

    // operand A source
    typedef enum logic {
        ASrcRs1 = 1'b0,
        ASrcPc  = 1'b1
    } aluASrc_t;

    // operand B source
    typedef enum logic [1:0] {
        BSrcRs2  = 2'd0,
        BSrcImm  = 2'd1,
        BSrcFour = 2'd2
    } aluBSrc_t;

    // unsigned compares pair AluSltu with BrLt/BrGe
    typedef enum logic [2:0] {
        BrNone = 3'd0,
        BrJal  = 3'd1,
        BrJalr = 3'd2,
        BrEq   = 3'd3,
        BrNe   = 3'd4,
        BrLt   = 3'd5,
        BrGe   = 3'd6
    } branch_t;

    // access size and sign, only passed on to the LSU
    typedef enum logic [2:0] {
        MemByte   = 3'd0,
        MemHalf   = 3'd1,
        MemWord   = 3'd2,
        MemDouble = 3'd3,
        MemByteU  = 3'd4,
        MemHalfU  = 3'd5,
        MemWordU  = 3'd6
    } memOp_t;

    // write-back source
    typedef enum logic [1:0] {
        RegSrcAlu = 2'd0,
        RegSrcMem = 2'd1,
        RegSrcCsr = 2'd2
    } regSrc_t;

endpackage

/* design/exuAlu.sv */
`timescale 1ns/1ps

module exuAlu
    import exuCfgPkg::*, exuCtrlPkg::*;
(
    input  aluASrc_t              aluASrc_i,
    input  aluBSrc_t              aluBSrc_i,
    input  aluOp_t                aluOp_i,
    input  logic                  isTruncate_i,
    input  logic                  isSext_i,
    input  logic [RegWidth-1:0]   pc_i,
    input  logic [RegWidth-1:0]   rs1_i,
    input  logic [RegWidth-1:0]   rs2_i,
    input  logic [RegWidth-1:0]   imm_i,
    output logic [RegWidth-1:0]   aluRes_o,
    output logic                  less_o,
    output logic                  zero_o
);

    logic [RegWidth-1:0] opA;
    logic [RegWidth-1:0] opB;
    logic [RegWidth-1:0] shiftA;
    logic [RegWidth-1:0] wordASext;
    logic [RegWidth-1:0] wordAZext;
    logic [RegWidth-1:0] rawRes;
    logic [5:0]          shamt;
    logic                signedLess;
    logic                unsignedLess;

    // operand muxes
    always_comb begin
        case (aluASrc_i)
            ASrcPc:  opA = pc_i;
            default: opA = rs1_i;
        endcase
    end

    always_comb begin
        case (aluBSrc_i)
            BSrcImm:  opB = imm_i;
            BSrcFour: opB = RegWidth'(4);
            default:  opB = rs2_i;
        endcase
    end

    assign signedLess   = $signed(opA) < $signed(opB);
    assign unsignedLess = opA < opB;

    // low word of A for the W shifts
    assign wordASext = {{(RegWidth-WordWidth){opA[WordWidth-1]}}, opA[WordWidth-1:0]};
    assign wordAZext = {{(RegWidth-WordWidth){1'b0}}, opA[WordWidth-1:0]};

    always_comb begin
        if (isTruncate_i) begin
            // sra needs the word sign in the upper bits
            shiftA = (aluOp_i == AluSra) ? wordASext : wordAZext;
            shamt  = {1'b0, opB[4:0]};
        end else begin
            shiftA = opA;
            shamt  = opB[5:0];
        end
    end

    always_comb begin
        case (aluOp_i)
            AluAdd:   rawRes = opA + opB;
            AluSub:   rawRes = opA - opB;
            AluSll:   rawRes = shiftA << shamt;
            AluSlt:   rawRes = {{(RegWidth-1){1'b0}}, signedLess};
            AluSltu:  rawRes = {{(RegWidth-1){1'b0}}, unsignedLess};
            AluXor:   rawRes = opA ^ opB;
            AluSrl:   rawRes = shiftA >> shamt;
            AluSra:   rawRes = $unsigned($signed(shiftA) >>> shamt);
            AluOr:    rawRes = opA | opB;
            AluAnd:   rawRes = opA & opB;
            AluCopyB: rawRes = opB;
            default:  rawRes = '0;
        endcase
    end

    // W-type results keep the low word only
    always_comb begin
        if (!isTruncate_i) begin
            aluRes_o = rawRes;
        end else if (isSext_i) begin
            aluRes_o = {{(RegWidth-WordWidth){rawRes[WordWidth-1]}},
                        rawRes[WordWidth-1:0]};
        end else begin
            aluRes_o = {{(RegWidth-WordWidth){1'b0}}, rawRes[WordWidth-1:0]};
        end
    end

    // flags for the branch unit
    assign less_o = (aluOp_i == AluSltu) ? unsignedLess : signedLess;
    assign zero_o = (rawRes == '0);

endmodule

/* design/exuNextPc.sv */
`timescale 1ns/1ps

module exuNextPc
    import exuCfgPkg::*, exuCtrlPkg::*;
(
    input  branch_t               branch_i,
    input  logic [RegWidth-1:0]   pc_i,
    input  logic [RegWidth-1:0]   rs1_i,
    input  logic [RegWidth-1:0]   imm_i,
    input  logic                  less_i,
    input  logic                  zero_i,
    output logic [RegWidth-1:0]   nextPc_o,
    output logic                  jump_o
);

    logic [RegWidth-1:0] pcTarget;
    logic [RegWidth-1:0] regTarget;
    logic [RegWidth-1:0] target;
    logic                taken;

    assign pcTarget  = pc_i + imm_i;
    assign regTarget = rs1_i + imm_i;

    // jalr clears bit 0 of the sum
    assign target = (branch_i == BrJalr) ? {regTarget[RegWidth-1:1], 1'b0} : pcTarget;

    always_comb begin
        case (branch_i)
            BrJal:   taken = 1'b1;
            BrJalr:  taken = 1'b1;
            BrEq:    taken = zero_i;
            BrNe:    taken = !zero_i;
            BrLt:    taken = less_i;
            BrGe:    taken = !less_i;
            default: taken = 1'b0;
        endcase
    end

    assign jump_o   = taken;
    assign nextPc_o = taken ? target : pc_i + RegWidth'(4);

endmodule

/* design/exuFlowCtrl.sv */
`timescale 1ns/1ps

module exuFlowCtrl (
    input  logic clk_i,
    input  logic arstN_i,
    input  logic idValid_i,
    input  logic lsuReady_i,
    input  logic jumpRaw_i,
    output logic exuReady_o,
    output logic exuValid_o,
    output logic loadEn_o,
    output logic isJump_o
);

    logic slotFull;

    // free when empty or drained this cycle
    assign exuReady_o = !slotFull || lsuReady_i;
    assign loadEn_o   = idValid_i && exuReady_o;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            slotFull <= 1'b0;
        end else if (exuReady_o) begin
            slotFull <= idValid_i;
        end
    end

    assign exuValid_o = slotFull;

    // redirect only with the accepted branch
    assign isJump_o = jumpRaw_i && loadEn_o;

endmodule

/* design/exuPipeReg.sv */
`timescale 1ns/1ps

module exuPipeReg
    import exuCfgPkg::*, exuCtrlPkg::*;
(
    input  logic                  clk_i,
    input  logic                  arstN_i,
    input  logic                  loadEn_i,
    input  logic [RegWidth-1:0]   aluRes_i,
    input  logic [RegWidth-1:0]   rs1_i,
    input  logic [RegWidth-1:0]   rs2_i,
    input  memOp_t                memOp_i,
    input  logic                  memWr_i,
    input  logic                  intrEn_i,
    input  regSrc_t               regSrc_i,
    input  logic                  regWr_i,
    input  logic [InstWidth-1:0]  inst_i,
    input  logic [RegWidth-1:0]   pc_i,
    output logic [RegWidth-1:0]   aluRes_o,
    output logic [RegWidth-1:0]   rs1_o,
    output logic [RegWidth-1:0]   rs2_o,
    output memOp_t                memOp_o,
    output logic                  memWr_o,
    output logic                  intrEn_o,
    output regSrc_t               regSrc_o,
    output logic                  regWr_o,
    output logic [InstWidth-1:0]  inst_o,
    output logic [RegWidth-1:0]   pc_o
);

    // result and LSU side-band
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            aluRes_o <= '0;
            rs1_o    <= '0;
            rs2_o    <= '0;
            memOp_o  <= MemByte;
            memWr_o  <= 1'b0;
            intrEn_o <= 1'b0;
        end else if (loadEn_i) begin
            aluRes_o <= aluRes_i;
            rs1_o    <= rs1_i;
            rs2_o    <= rs2_i;
            memOp_o  <= memOp_i;
            memWr_o  <= memWr_i;
            intrEn_o <= intrEn_i;
        end
    end

    // write-back control and instruction tag
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            regSrc_o <= RegSrcAlu;
            regWr_o  <= 1'b0;
            inst_o   <= '0;
            pc_o     <= '0;
        end else if (loadEn_i) begin
            regSrc_o <= regSrc_i;
            regWr_o  <= regWr_i;
            inst_o   <= inst_i;
            pc_o     <= pc_i;
        end
    end

endmodule

/* design/exuTop.sv */
`timescale 1ns/1ps

module exuTop
    import exuCfgPkg::*, exuCtrlPkg::*;
(
    input  logic                  clk_i,
    input  logic                  arstN_i,

    // decode side
    input  logic                  idValid_i,
    output logic                  exuReady_o,
    input  logic [InstWidth-1:0]  inst_i,
    input  logic [RegWidth-1:0]   pc_i,
    input  aluASrc_t              aluASrc_i,
    input  aluBSrc_t              aluBSrc_i,
    input  aluOp_t                aluOp_i,
    input  logic                  isTruncate_i,
    input  logic                  isSext_i,
    input  logic                  regWr_i,
    input  memOp_t                memOp_i,
    input  logic                  memWr_i,
    input  logic                  intrEn_i,
    input  branch_t               branch_i,
    input  regSrc_t               regSrc_i,
    input  logic [RegWidth-1:0]   rs1_i,
    input  logic [RegWidth-1:0]   rs2_i,
    input  logic [RegWidth-1:0]   imm_i,

    // redirect toward fetch
    output logic [RegWidth-1:0]   nextPc_o,
    output logic                  isJump_o,

    // LSU side
    output logic                  exuValid_o,
    input  logic                  lsuReady_i,
    output logic [RegWidth-1:0]   aluRes_o,
    output logic                  regWr_o,
    output logic [RegWidth-1:0]   rs1_o,
    output logic [RegWidth-1:0]   rs2_o,
    output memOp_t                memOp_o,
    output logic                  memWr_o,
    output logic                  intrEn_o,
    output regSrc_t               regSrc_o,
    output logic [InstWidth-1:0]  inst_o,
    output logic [RegWidth-1:0]   pc_o
);

    logic [RegWidth-1:0] aluRes;
    logic                less;
    logic                zero;
    logic                jumpRaw;
    logic                loadEn;

    exuFlowCtrl uFlowCtrl (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .idValid_i  (idValid_i),
        .lsuReady_i (lsuReady_i),
        .jumpRaw_i  (jumpRaw),
        .exuReady_o (exuReady_o),
        .exuValid_o (exuValid_o),
        .loadEn_o   (loadEn),
        .isJump_o   (isJump_o)
    );

    exuAlu uAlu (
        .aluASrc_i    (aluASrc_i),
        .aluBSrc_i    (aluBSrc_i),
        .aluOp_i      (aluOp_i),
        .isTruncate_i (isTruncate_i),
        .isSext_i     (isSext_i),
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .imm_i        (imm_i),
        .aluRes_o     (aluRes),
        .less_o       (less),
        .zero_o       (zero)
    );

    exuNextPc uNextPc (
        .branch_i (branch_i),
        .pc_i     (pc_i),
        .rs1_i    (rs1_i),
        .imm_i    (imm_i),
        .less_i   (less),
        .zero_i   (zero),
        .nextPc_o (nextPc_o),
        .jump_o   (jumpRaw)
    );

    exuPipeReg uPipeReg (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .loadEn_i (loadEn),
        .aluRes_i (aluRes),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .memOp_i  (memOp_i),
        .memWr_i  (memWr_i),
        .intrEn_i (intrEn_i),
        .regSrc_i (regSrc_i),
        .regWr_i  (regWr_i),
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .aluRes_o (aluRes_o),
        .rs1_o    (rs1_o),
        .rs2_o    (rs2_o),
        .memOp_o  (memOp_o),
        .memWr_o  (memWr_o),
        .intrEn_o (intrEn_o),
        .regSrc_o (regSrc_o),
        .regWr_o  (regWr_o),
        .inst_o   (inst_o),
        .pc_o     (pc_o)
    );

endmodule

/* tb/exuTb.sv */
`timescale 1ns/1ps

module exuTb
    import exuCfgPkg::*, exuCtrlPkg::*;
();

    localparam int SideWidth = 3 * RegWidth + InstWidth + 8;
    localparam int WaitLimit = 64;
    localparam int StreamLen = 64;
    localparam logic [RegWidth-1:0] MsbOnly = {1'b1, {(RegWidth-1){1'b0}}};

    typedef struct packed {
        logic [RegWidth-1:0]  res;
        logic [SideWidth-1:0] side;
    } entry_t;

    logic                 clk_i;
    logic                 arstN_i;
    logic                 idValid_i;
    logic                 exuReady_o;
    logic [InstWidth-1:0] inst_i;
    logic [RegWidth-1:0]  pc_i;
    aluASrc_t             aluASrc_i;
    aluBSrc_t             aluBSrc_i;
    aluOp_t               aluOp_i;
    logic                 isTruncate_i;
    logic                 isSext_i;
    logic                 regWr_i;
    memOp_t               memOp_i;
    logic                 memWr_i;
    logic                 intrEn_i;
    branch_t              branch_i;
    regSrc_t              regSrc_i;
    logic [RegWidth-1:0]  rs1_i;
    logic [RegWidth-1:0]  rs2_i;
    logic [RegWidth-1:0]  imm_i;
    logic [RegWidth-1:0]  nextPc_o;
    logic                 isJump_o;
    logic                 exuValid_o;
    logic                 lsuReady_i;
    logic [RegWidth-1:0]  aluRes_o;
    logic                 regWr_o;
    logic [RegWidth-1:0]  rs1_o;
    logic [RegWidth-1:0]  rs2_o;
    memOp_t               memOp_o;
    logic                 memWr_o;
    logic                 intrEn_o;
    regSrc_t              regSrc_o;
    logic [InstWidth-1:0] inst_o;
    logic [RegWidth-1:0]  pc_o;

    int     seed = 32'h641e6e51;
    int     errCount = 0;
    int     acceptCount = 0;
    int     drainCount = 0;
    int     cycleCount = 0;
    bit     stallOn;
    bit     timedOut;
    bit     lastAccept;
    entry_t expQ[$];
    entry_t expHead;
    logic   expFull;
    logic   stalled;
    logic   expAccept;
    logic   expJump;
    logic   lessExp;
    logic [RegWidth-1:0]           opA;
    logic [RegWidth-1:0]           opB;
    logic [RegWidth-1:0]           rawExp;
    logic [RegWidth-1:0]           expRes;
    logic [RegWidth-1:0]           target;
    logic [RegWidth-1:0]           expNextPc;
    logic [SideWidth-1:0]          sideIn;
    logic [SideWidth-1:0]          sideOut;
    logic [RegWidth+SideWidth-1:0] heldOut;

    exuTop dut (.*);

    always #4 clk_i = ~clk_i;

    assign sideIn  = {rs1_i, rs2_i, pc_i, inst_i, memOp_i, memWr_i, intrEn_i,
                      regSrc_i, regWr_i};
    assign sideOut = {rs1_o, rs2_o, pc_o, inst_o, memOp_o, memWr_o, intrEn_o,
                      regSrc_o, regWr_o};

    function automatic int randBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [RegWidth-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // signed compare by flipping the sign bits
    function automatic logic signedBelow(logic [RegWidth-1:0] a, logic [RegWidth-1:0] b);
        return (a ^ MsbOnly) < (b ^ MsbOnly);
    endfunction

    function automatic logic [RegWidth-1:0] rawResult(aluOp_t op, logic [RegWidth-1:0] a,
                                                      logic [RegWidth-1:0] b, logic w);
        logic [RegWidth-1:0] src;
        logic [RegWidth-1:0] fill;
        int                  sh;
        sh   = w ? int'(b[4:0]) : int'(b[5:0]);
        src  = w ? {{(RegWidth-WordWidth){op == AluSra && a[WordWidth-1]}},
                    a[WordWidth-1:0]} : a;
        fill = src[RegWidth-1] ? ~({RegWidth{1'b1}} >> sh) : '0;
        case (op)
            AluAdd:   return a + b;
            AluSub:   return a + ~b + 1;
            AluSll:   return src << sh;
            AluSlt:   return RegWidth'(signedBelow(a, b));
            AluSltu:  return RegWidth'(a < b);
            AluXor:   return a ^ b;
            AluSrl:   return src >> sh;
            AluSra:   return (src >> sh) | fill;
            AluOr:    return a | b;
            AluAnd:   return a & b;
            AluCopyB: return b;
            default:  return '0;
        endcase
    endfunction

    // expected view of whatever sits on the decode side
    always_comb begin
        opA = (aluASrc_i == ASrcPc) ? pc_i : rs1_i;
        case (aluBSrc_i)
            BSrcImm:  opB = imm_i;
            BSrcFour: opB = RegWidth'(4);
            default:  opB = rs2_i;
        endcase
        rawExp = rawResult(aluOp_i, opA, opB, isTruncate_i);
        if (!isTruncate_i) begin
            expRes = rawExp;
        end else begin
            expRes = {{(RegWidth-WordWidth){isSext_i & rawExp[WordWidth-1]}},
                      rawExp[WordWidth-1:0]};
        end
        lessExp = (aluOp_i == AluSltu) ? (opA < opB) : signedBelow(opA, opB);
        target  = (branch_i == BrJalr) ? ((rs1_i + imm_i) & ~RegWidth'(1)) : pc_i + imm_i;
        case (branch_i)
            BrJal, BrJalr: expJump = 1'b1;
            BrEq:          expJump = (rawExp == '0);
            BrNe:          expJump = (rawExp != '0);
            BrLt:          expJump = lessExp;
            BrGe:          expJump = !lessExp;
            default:       expJump = 1'b0;
        endcase
        expNextPc = expJump ? target : pc_i + RegWidth'(4);
        expAccept = idValid_i && (!expFull || lsuReady_i);
    end

    // scoreboard of the single LSU slot
    always @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            expQ.delete();
            expHead <= '0;
            expFull <= 1'b0;
            stalled <= 1'b0;
            heldOut <= '0;
        end else begin
            if (exuValid_o && lsuReady_i) begin
                drainCount++;
            end
            if (expFull && lsuReady_i) begin
                void'(expQ.pop_front());
            end
            if (expAccept) begin
                expQ.push_back(entry_t'({expRes, sideIn}));
                acceptCount++;
            end
            expFull <= (expQ.size() != 0);
            if (expQ.size() != 0) begin
                expHead <= expQ[0];
            end
            stalled <= exuValid_o && !lsuReady_i;
            heldOut <= {aluRes_o, sideOut};
        end
    end

    task automatic flagError(input string msg);
        errCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    resetState: assert property (@(posedge clk_i) !arstN_i |->
        (!exuValid_o && !isJump_o && exuReady_o && {aluRes_o, sideOut} == '0))
        else flagError("outputs not at their reset values");
    readyRule: assert property (@(posedge clk_i) disable iff (!arstN_i)
        exuReady_o == (!expFull || lsuReady_i))
        else flagError("exuReady_o does not follow the slot state");
    stallBlocks: assert property (@(posedge clk_i) disable iff (!arstN_i)
        (exuValid_o && !lsuReady_i) |-> !exuReady_o)
        else flagError("exuReady_o high while the slot is stalled");
    slotValid: assert property (@(posedge clk_i) disable iff (!arstN_i)
        exuValid_o == expFull)
        else flagError($sformatf("exuValid_o %b, expected %b", $sampled(exuValid_o),
                                 $sampled(expFull)));
    jumpStrobe: assert property (@(posedge clk_i) disable iff (!arstN_i)
        isJump_o == (expAccept && expJump))
        else flagError($sformatf("isJump_o %b, expected %b", $sampled(isJump_o),
                                 $sampled(expAccept && expJump)));
    nextPcMatch: assert property (@(posedge clk_i) disable iff (!arstN_i)
        idValid_i |-> nextPc_o == expNextPc)
        else flagError($sformatf("nextPc_o %h, expected %h", $sampled(nextPc_o),
                                 $sampled(expNextPc)));
    resultMatch: assert property (@(posedge clk_i) disable iff (!arstN_i)
        exuValid_o |-> aluRes_o == expHead.res)
        else flagError($sformatf("aluRes_o %h, expected %h", $sampled(aluRes_o),
                                 $sampled(expHead.res)));
    sideMatch: assert property (@(posedge clk_i) disable iff (!arstN_i)
        exuValid_o |-> sideOut == expHead.side)
        else flagError("side-band fields differ from the accepted instruction");
    stallHold: assert property (@(posedge clk_i) disable iff (!arstN_i)
        stalled |-> {aluRes_o, sideOut} == heldOut)
        else flagError("registered outputs changed during back-pressure");

    // one clock, then a new LSU ready at the drive offset
    task automatic tick();
        @(posedge clk_i);
        lastAccept = idValid_i && exuReady_o;
        cycleCount++;
        #1;
        lsuReady_i = stallOn ? (randBelow(3) != 0) : 1'b1;
    endtask

    task automatic issue();
        int waited;
        waited     = 0;
        idValid_i  = 1'b1;
        lastAccept = 1'b0;
        while (!lastAccept && !timedOut) begin
            tick();
            waited++;
            if (!lastAccept && waited >= WaitLimit) begin
                $display("Timeout: instruction not accepted within %0d cycles", WaitLimit);
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic randomSide();
        inst_i   = $random(seed);
        pc_i     = rand64() & ~RegWidth'(3);
        rs1_i    = rand64();
        rs2_i    = (randBelow(4) == 0) ? rs1_i : rand64();
        imm_i    = rand64();
        memOp_i  = memOp_t'(randBelow(7));
        memWr_i  = 1'(randBelow(2));
        intrEn_i = 1'(randBelow(2));
        regSrc_i = regSrc_t'(randBelow(3));
        regWr_i  = 1'(randBelow(2));
    endtask

    task automatic branchFields();
        branch_i     = branch_t'(randBelow(7));
        isTruncate_i = 1'b0;
        isSext_i     = 1'b0;
        aluASrc_i    = ASrcRs1;
        aluBSrc_i    = BSrcRs2;
        case (branch_i)
            BrJal, BrJalr: begin
                // link value pc + 4
                aluOp_i   = AluAdd;
                aluASrc_i = ASrcPc;
                aluBSrc_i = BSrcFour;
            end
            BrEq, BrNe: aluOp_i = AluSub;
            BrLt, BrGe: aluOp_i = (randBelow(2) != 0) ? AluSltu : AluSlt;
            default:    aluOp_i = aluOp_t'(randBelow(11));
        endcase
    endtask

    task automatic endTest(input string name, inout int mark);
        $display("test %s done, %0d errors", name, errCount - mark);
        mark = errCount;
    endtask

    initial begin
        int mark;
        int start;
        int waited;
        mark         = 0;
        clk_i        = 1'b0;
        arstN_i      = 1'b0;
        idValid_i    = 1'b0;
        lsuReady_i   = 1'b1;
        stallOn      = 1'b0;
        timedOut     = 1'b0;
        branch_i     = BrNone;
        aluOp_i      = AluAdd;
        aluASrc_i    = ASrcRs1;
        aluBSrc_i    = BSrcRs2;
        isTruncate_i = 1'b0;
        isSext_i     = 1'b0;
        randomSide();

        repeat (16) @(posedge clk_i);
        #1;
        arstN_i = 1'b1;
        repeat (3) tick();
        endTest("reset", mark);

        stallOn = 1'b1;
        for (int op = 0; op < 11; op++) begin
            for (int a = 0; a < 2; a++) begin
                for (int b = 0; b < 3; b++) begin
                    for (int m = 0; m < 3; m++) begin
                        randomSide();
                        branch_i     = BrNone;
                        aluOp_i      = aluOp_t'(op);
                        aluASrc_i    = aluASrc_t'(a);
                        aluBSrc_i    = aluBSrc_t'(b);
                        isTruncate_i = (m != 0);
                        isSext_i     = (m == 2);
                        issue();
                    end
                end
            end
        end
        endTest("alu sweep", mark);

        // idle gaps check the jump strobe without acceptance
        for (int i = 0; i < 300; i++) begin
            randomSide();
            branchFields();
            if (randBelow(4) == 0) begin
                idValid_i = 1'b0;
                tick();
            end
            issue();
        end
        endTest("branch", mark);

        stallOn = 1'b0;
        tick();
        start = cycleCount;
        for (int i = 0; i < StreamLen; i++) begin
            randomSide();
            branchFields();
            issue();
        end
        streamRate: assert (timedOut || cycleCount - start == StreamLen)
            else flagError($sformatf("%0d instructions took %0d cycles", StreamLen,
                                     cycleCount - start));
        endTest("stream", mark);

        idValid_i = 1'b0;
        waited    = 0;
        while (exuValid_o && !timedOut) begin
            tick();
            waited++;
            if (exuValid_o && waited >= WaitLimit) begin
                $display("Timeout: result slot did not drain within %0d cycles", WaitLimit);
                timedOut = 1'b1;
            end
        end
        countMatch: assert (acceptCount == drainCount)
            else flagError($sformatf("%0d accepted, %0d drained", acceptCount, drainCount));
        endTest("drain", mark);

        $display("tests 5, accepted %0d, drained %0d, errors %0d",
                 acceptCount, drainCount, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/exuCfgPkg.sv
design/exuCtrlPkg.sv
design/exuAlu.sv
design/exuNextPc.sv
design/exuFlowCtrl.sv
design/exuPipeReg.sv
design/exuTop.sv
tb/exuTb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - target: any(design, test)
    files:
      - design/exuCfgPkg.sv
      - design/exuCtrlPkg.sv
      - design/exuAlu.sv
      - design/exuNextPc.sv
      - design/exuFlowCtrl.sv
      - design/exuPipeReg.sv
      - design/exuTop.sv
  - target: test
    files:
      - tb/exuTb.sv
